// ==== verilog/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data path and bus widths
`define CPU_WIDTH      32
`define CPU_ADDR_SIZE  32

// register file indexing
`define CPU_REG_BITS   4
`define CPU_LINK_REG   14   // return address on call
`define CPU_PC_REG     15   // program counter

`endif

// ==== verilog/cpu_pkg.sv ====
`include "cpu_macros.svh"

package cpu_pkg;

   typedef enum logic [2:0] {
      opc_nop, opc_ld, opc_st, opc_mov, opc_ldl0, opc_ldl, opc_ldh, opc_op
   } opcode_e;

   // unlisted codes give a zero result
   typedef enum logic [4:0] {
      alu_add, alu_adc, alu_sub, alu_sbc, alu_and,
      alu_or, alu_xor, alu_shl, alu_shr, alu_passb
   } alu_op_e;

   typedef enum logic [2:0] {
      wb_target, wb_mem, wb_ra, wb_lit0, wb_litl, wb_lith, wb_alu
   } wb_sel_e;

   // one instruction word, seen either as a call or as a register op
   typedef union packed {
      struct packed {
         logic [1:0]  cond_flag;    // 00 s, 01 c, 10 z, 11 v
         logic        cond_value;
         logic        cond_always;  // set means check the flag
         logic        call;
         logic [26:0] target;
      } c;
      struct packed {
         logic [1:0]               cond_flag;
         logic                     cond_value;
         logic                     cond_always;
         logic                     call;
         opcode_e                  opcode;
         logic [`CPU_REG_BITS-1:0] rd;
         logic [`CPU_REG_BITS-1:0] ra;
         logic [`CPU_REG_BITS-1:0] rb;   // top of the literal
         alu_op_e                  alu_op;
         logic [6:0]               unused;
      } r;
   } inst_t;

endpackage

// ==== verilog/schedm.sv ====
`timescale 1ns/1ns

module schedm (
   input  logic clk,
   input  logic arst_n,
   output logic phf,
   output logic phe,
   output logic phm,
   output logic phw
);

   logic [3:0] ring;   // one-hot phase ring

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ring <= 4'b0001;   // fetch first
      end else begin
         ring <= {ring[2:0], ring[3]};
      end
   end

   assign phf = ring[0];  // fetch into IR
   assign phe = ring[1];  // pc increment, link
   assign phm = ring[2];  // memory access
   assign phw = ring[3];  // writeback, flags

endmodule

// ==== verilog/inst_decode.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module inst_decode import cpu_pkg::*; (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      phf,
   input  logic                      phe,
   input  logic                      phm,
   input  logic                      phw,
   input  logic [`CPU_WIDTH-1:0]     mbus_din,
   input  logic [`CPU_WIDTH-1:0]     opa,
   input  logic [`CPU_WIDTH-1:0]     pc,
   input  logic                      c_res,
   input  logic                      z_res,
   input  logic                      s_res,
   input  logic                      v_res,
   output logic [`CPU_REG_BITS-1:0]  ra,
   output logic [`CPU_REG_BITS-1:0]  rb,
   output logic [`CPU_REG_BITS-1:0]  rd,
   output alu_op_e                   alu_op,
   output logic                      flag_c,
   output logic                      flag_z,
   output logic                      flag_s,
   output logic                      flag_v,
   output wb_sel_e                   wb_sel,
   output logic                      wb_en,
   output logic                      link_en,
   output logic [`CPU_WIDTH-1:0]     jump_target,
   output logic [15:0]               literal,
   output logic [`CPU_ADDR_SIZE-1:0] mbus_aout,
   output logic                      mbus_wen
);

   inst_t ir;
   logic  ena;        // condition passed
   logic  inst_op;
   logic  inst_ld;
   logic  inst_st;
   logic  inst_wb;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ir <= '0;   // decodes as nop
         {flag_v, flag_z, flag_s, flag_c} <= 4'b0000;
      end else begin
         if (phf) ir <= mbus_din;
         if (phw && ena && inst_op) begin
            {flag_v, flag_z, flag_s, flag_c} <= {v_res, z_res, s_res, c_res};
         end
      end
   end

   assign ra          = ir.r.ra;
   assign rb          = ir.r.rb;
   assign rd          = ir.r.rd;
   assign alu_op      = ir.r.alu_op;
   assign literal     = {ir.r.rb, ir.r.alu_op, ir.r.unused};
   assign jump_target = {{(`CPU_WIDTH-27){1'b0}}, ir.c.target};

   assign inst_op = !ir.r.call && (ir.r.opcode == opc_op);
   assign inst_ld = !ir.r.call && (ir.r.opcode == opc_ld);
   assign inst_st = !ir.r.call && (ir.r.opcode == opc_st);
   assign inst_wb = ir.r.call || !(ir.r.opcode inside {opc_nop, opc_st});

   // flag test, skipped when always-check is clear
   always_comb begin
      case (ir.c.cond_flag)
         2'b00:   ena = (ir.c.cond_value == flag_s);
         2'b01:   ena = (ir.c.cond_value == flag_c);
         2'b10:   ena = (ir.c.cond_value == flag_z);
         default: ena = (ir.c.cond_value == flag_v);
      endcase
      if (!ir.c.cond_always) ena = 1'b1;
   end

   always_comb begin
      if (ir.r.call) begin
         wb_sel = wb_target;
      end else begin
         case (ir.r.opcode)
            opc_ld:   wb_sel = wb_mem;
            opc_mov:  wb_sel = wb_ra;
            opc_ldl0: wb_sel = wb_lit0;
            opc_ldl:  wb_sel = wb_litl;
            opc_ldh:  wb_sel = wb_lith;
            default:  wb_sel = wb_alu;   // op, nop and st
         endcase
      end
   end

   assign wb_en   = ena && inst_wb;             // qualified by phw in rfm
   assign link_en = ena && ir.c.call && phe;

   assign mbus_aout = ((phm && inst_st) || (inst_ld && (phm || phw))) ? opa : pc;
   assign mbus_wen  = ena && phm && inst_st;

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module alu import cpu_pkg::*; (
   input  alu_op_e                  alu_op,
   input  logic [`CPU_WIDTH-1:0]    opa,
   input  logic [`CPU_WIDTH-1:0]    opb,
   input  logic                     flag_c,
   output logic [`CPU_WIDTH-1:0]    alu_res,
   output logic                     c_res,
   output logic                     v_res,
   output logic                     z_res,
   output logic                     s_res
);

   localparam int W = `CPU_WIDTH;

   logic         is_sub;
   logic         cin;
   logic [W-1:0] b_in;   // adder b operand, inverted for subtract
   logic [W:0]   sum;

   // one adder serves all four arithmetic ops
   always_comb begin
      is_sub = (alu_op == alu_sub) || (alu_op == alu_sbc);
      case (alu_op)
         alu_adc: cin = flag_c;
         alu_sub: cin = 1'b1;
         alu_sbc: cin = !flag_c;   // borrow in
         default: cin = 1'b0;
      endcase
      b_in = is_sub ? ~opb : opb;
      sum  = {1'b0, opa} + {1'b0, b_in} + {{W{1'b0}}, cin};
   end

   always_comb begin
      alu_res = '0;
      c_res   = 1'b0;
      v_res   = 1'b0;
      case (alu_op)
         alu_add, alu_adc, alu_sub, alu_sbc: begin
            alu_res = sum[W-1:0];
            c_res   = is_sub ? !sum[W] : sum[W];   // borrow for subtract
            v_res   = (opa[W-1] == b_in[W-1]) && (sum[W-1] != opa[W-1]);
         end
         alu_and: alu_res = opa & opb;
         alu_or:  alu_res = opa | opb;
         alu_xor: alu_res = opa ^ opb;
         alu_shl: begin
            alu_res = {opa[W-2:0], 1'b0};   // one bit per op
            c_res   = opa[W-1];
         end
         alu_shr: begin
            alu_res = {1'b0, opa[W-1:1]};
            c_res   = opa[0];
         end
         alu_passb: alu_res = opb;
         default: ;
      endcase
   end

   assign z_res = (alu_res == '0);
   assign s_res = alu_res[W-1];

endmodule

// ==== verilog/rfm.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module rfm import cpu_pkg::*; (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     phe,
   input  logic                     phw,
   input  logic                     wb_en,
   input  logic                     link_en,
   input  wb_sel_e                  wb_sel,
   input  logic [`CPU_REG_BITS-1:0] ra,
   input  logic [`CPU_REG_BITS-1:0] rb,
   input  logic [`CPU_REG_BITS-1:0] rd,
   input  logic [`CPU_REG_BITS-1:0] test_sel,
   input  logic [`CPU_WIDTH-1:0]    jump_target,
   input  logic [15:0]              literal,
   input  logic [`CPU_WIDTH-1:0]    mbus_din,
   input  logic [`CPU_WIDTH-1:0]    alu_res,
   output logic [`CPU_WIDTH-1:0]    opa,
   output logic [`CPU_WIDTH-1:0]    opb,
   output logic [`CPU_WIDTH-1:0]    opd,
   output logic [`CPU_WIDTH-1:0]    test_out,
   output logic [`CPU_WIDTH-1:0]    pc
);

   localparam int NREGS = 2 ** `CPU_REG_BITS;

   logic [`CPU_WIDTH-1:0]    regs [NREGS];
   logic [`CPU_WIDTH-1:0]    pc_next;
   logic [`CPU_WIDTH-1:0]    wb_data;
   logic [`CPU_REG_BITS-1:0] wb_address;

   assign opa      = regs[ra];
   assign opb      = regs[rb];
   assign opd      = regs[rd];
   assign test_out = regs[test_sel];
   assign pc       = regs[`CPU_PC_REG];
   assign pc_next  = pc + `CPU_WIDTH'(1);   // also the return address

   always_comb begin
      case (wb_sel)
         wb_target: wb_data = jump_target;
         wb_mem:    wb_data = mbus_din;
         wb_ra:     wb_data = opa;
         wb_lit0:   wb_data = {{(`CPU_WIDTH-16){1'b0}}, literal};
         wb_litl:   wb_data = {opd[`CPU_WIDTH-1:16], literal};   // keep high half
         wb_lith:   wb_data = {literal, opd[15:0]};              // keep low half
         default:   wb_data = alu_res;
      endcase
   end

   // call always lands in the pc
   assign wb_address = (wb_sel == wb_target) ? `CPU_REG_BITS'(`CPU_PC_REG) : rd;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < NREGS; i++) regs[i] <= '0;
      end else begin
         if (phe) regs[`CPU_PC_REG] <= pc_next;
         if (link_en) regs[`CPU_LINK_REG] <= pc_next;
         if (phw && wb_en) regs[wb_address] <= wb_data;
      end
   end

endmodule

// ==== verilog/cpu.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpu import cpu_pkg::*; (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic [`CPU_WIDTH-1:0]     mbus_din,
   input  logic [`CPU_REG_BITS-1:0]  test_sel,
   output logic [`CPU_ADDR_SIZE-1:0] mbus_aout,
   output logic [`CPU_WIDTH-1:0]     mbus_dout,
   output logic                      mbus_wen,
   output logic [`CPU_WIDTH-1:0]     test_out
);

   // phase strobes
   logic phf, phe, phm, phw;

   // operands and results
   logic [`CPU_WIDTH-1:0]    opa, opb, opd, pc;
   logic [`CPU_WIDTH-1:0]    alu_res;
   logic                     c_res, z_res, s_res, v_res;
   logic                     flag_c, flag_z, flag_s, flag_v;

   // decoded controls
   logic [`CPU_REG_BITS-1:0] ra, rb, rd;
   alu_op_e                  alu_op;
   wb_sel_e                  wb_sel;
   logic                     wb_en, link_en;
   logic [`CPU_WIDTH-1:0]    jump_target;
   logic [15:0]              literal;

   schedm scheduler (.clk, .arst_n, .phf, .phe, .phm, .phw);

   inst_decode decoder (
      .clk, .arst_n, .phf, .phe, .phm, .phw, .mbus_din, .opa, .pc,
      .c_res, .z_res, .s_res, .v_res,
      .ra, .rb, .rd, .alu_op, .flag_c, .flag_z, .flag_s, .flag_v,
      .wb_sel, .wb_en, .link_en, .jump_target, .literal, .mbus_aout, .mbus_wen
   );

   alu alu_inst (
      .alu_op, .opa, .opb, .flag_c,
      .alu_res, .c_res, .v_res, .z_res, .s_res
   );

   rfm regs (
      .clk, .arst_n, .phe, .phw, .wb_en, .link_en, .wb_sel,
      .ra, .rb, .rd, .test_sel, .jump_target, .literal, .mbus_din, .alu_res,
      .opa, .opb, .opd, .test_out, .pc
   );

   assign mbus_dout = opd;   // store data is Rd

endmodule

// ==== tests/cpu_checker.sv ====
`timescale 1ns/1ns

module cpu_checker (
   input  logic        clk,
   input  logic        arst_n,
   input  logic [31:0] test_out,
   input  logic [31:0] mbus_aout,
   input  logic [31:0] mbus_dout,
   input  logic        mbus_wen,
   input  logic        check_en,
   input  logic [31:0] exp_val,
   input  logic        exp_st,
   input  logic [31:0] exp_addr,
   input  logic [31:0] exp_data,
   output int          errors
);

   int writes = 0;   // bus writes since reset

   initial errors = 0;

   // sampled mid cycle, away from the driving edge
   always @(negedge clk) begin
      if (!arst_n) begin
         writes <= 0;
      end else begin
         if (mbus_wen) begin
            writes <= writes + 1;
            if (!exp_st) begin
               $display("bus write at %0t to %h but no store expected", $time, mbus_aout);
               errors <= errors + 1;
            end else if (mbus_aout != exp_addr || mbus_dout != exp_data) begin
               $display("Mismatch at %0t: store %h to %h, expected %h to %h",
                  $time, mbus_dout, mbus_aout, exp_data, exp_addr);
               errors <= errors + 1;
            end
         end
         if (check_en) begin
            if (test_out !== exp_val) begin
               $display("Mismatch at %0t: register read %h, expected %h",
                  $time, test_out, exp_val);
               errors <= errors + 1;
            end else if (exp_st && writes != 1) begin
               $display("expected store seen %0d times instead of once", writes);
               errors <= errors + 1;
            end
         end
      end
   end

endmodule

// ==== tests/cpu_props.sv ====
`timescale 1ns/1ns

module cpu_props (
   input logic        clk,
   input logic        arst_n,
   input logic        phf,
   input logic        phe,
   input logic        phm,
   input logic        phw,
   input logic        mbus_wen,
   input logic [31:0] pc,
   input logic [3:0]  flags
);

   one_phase: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot({phf, phe, phm, phw})) else $error("phase strobes not one-hot");

   wen_in_phm: assert property (@(posedge clk) disable iff (!arst_n)
      mbus_wen |-> phm) else $error("bus write outside memory phase");

   pc_step: assert property (@(posedge clk) disable iff (!arst_n)
      phe |=> (pc == $past(pc) + 32'd1)) else $error("pc did not advance after execute");

   flags_in_phw: assert property (@(posedge clk) disable iff (!arst_n)
      (flags != $past(flags)) |-> $past(phw)) else $error("flags changed outside writeback");

endmodule

bind cpu cpu_props props_inst (
   .clk, .arst_n, .phf, .phe, .phm, .phw, .mbus_wen, .pc,
   .flags({flag_v, flag_z, flag_s, flag_c})
);

// ==== tests/tb_cpu.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module tb_cpu import cpu_pkg::*;;

   localparam int NT = 10;            // table entries
   localparam int LIMIT = NT * 40 + 100;
   localparam logic [3:0] AL = 4'b0000;    // no flag test
   localparam logic [3:0] IF_NZ = 4'b1001; // z must be 0
   localparam logic [3:0] IF_Z = 4'b1011;  // z must be 1

   logic                      clk = 1'b0;
   logic                      arst_n;
   logic [`CPU_WIDTH-1:0]     mbus_din;
   logic [`CPU_REG_BITS-1:0]  test_sel;
   logic [`CPU_ADDR_SIZE-1:0] mbus_aout;
   logic [`CPU_WIDTH-1:0]     mbus_dout;
   logic                      mbus_wen;
   logic [`CPU_WIDTH-1:0]     test_out;

   logic [31:0] mem [256];
   logic [31:0] prog [NT][8];
   logic [3:0]  chk_reg [NT];
   logic [31:0] exp_tab [NT];
   logic        st_tab [NT];
   logic [31:0] st_addr_tab [NT];
   logic [31:0] st_data_tab [NT];

   int          cur = 0;
   int          cycles = 0;
   int          errors;
   integer      seed = 32'hdb690da4;
   logic [31:0] k;
   logic [31:0] m;
   logic        check_en = 1'b0;
   logic        exp_st = 1'b0;
   logic [31:0] exp_val = '0;
   logic [31:0] exp_addr = '0;
   logic [31:0] exp_data = '0;

   always #4 clk = ~clk;

   cpu cpu_inst (.clk, .arst_n, .mbus_din, .test_sel, .mbus_aout, .mbus_dout, .mbus_wen,
      .test_out);

   cpu_checker checker_inst (.clk, .arst_n, .test_out, .mbus_aout, .mbus_dout, .mbus_wen,
      .check_en, .exp_val, .exp_st, .exp_addr, .exp_data, .errors);

   assign mbus_din = mem[mbus_aout[7:0]];   // zero wait state

   // program loaded during reset with address nops above it
   always @(posedge clk) begin
      if (!arst_n) begin
         for (int i = 0; i < 256; i++) mem[i] <= (i < 8) ? prog[cur][i] : 32'(i);
      end else if (mbus_wen) begin
         mem[mbus_aout[7:0]] <= mbus_dout;
      end
   end

   function automatic logic [31:0] reg_form(input logic [3:0] cond, input opcode_e opc,
         input logic [3:0] rd, input logic [3:0] ra, input logic [3:0] rb, input alu_op_e aop);
      inst_t i;
      i = '0;
      {i.r.cond_flag, i.r.cond_value, i.r.cond_always} = cond;
      i.r.opcode = opc;
      i.r.rd = rd;
      i.r.ra = ra;
      i.r.rb = rb;
      i.r.alu_op = aop;
      return i;
   endfunction

   function automatic logic [31:0] lit_form(input logic [3:0] cond, input opcode_e opc,
         input logic [3:0] rd, input logic [15:0] lit);
      inst_t i;
      i = reg_form(cond, opc, rd, 4'd0, lit[15:12], alu_op_e'(lit[11:7]));
      i.r.unused = lit[6:0];
      return i;
   endfunction

   function automatic logic [31:0] call_form(input logic [26:0] target);
      inst_t i;
      i = '0;
      i.c.call = 1'b1;
      i.c.target = target;
      return i;
   endfunction

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > LIMIT) begin
         $display("timeout: program table did not finish after %0d cycles", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      arst_n = 1'b0;
      test_sel = '0;
      k = $random(seed);
      m = $random(seed);
      for (int t = 0; t < NT; t++) begin
         for (int w = 0; w < 8; w++) prog[t][w] = 32'h0;   // nop
         st_tab[t] = 1'b0;
         st_addr_tab[t] = '0;
         st_data_tab[t] = '0;
      end
      // literal halves and move
      prog[0][0] = lit_form(AL, opc_ldl0, 4'd1, ~k[15:0]);
      prog[0][1] = lit_form(AL, opc_ldh, 4'd1, k[31:16]);
      prog[0][2] = lit_form(AL, opc_ldl, 4'd1, k[15:0]);   // keeps the high half
      prog[0][3] = reg_form(AL, opc_mov, 4'd2, 4'd1, 4'd0, alu_add);
      chk_reg[0] = 4'd2;
      exp_tab[0] = k;
      // add carries out and adc picks it up as 1 + 1 + 1
      prog[1][0] = lit_form(AL, opc_ldl0, 4'd1, 16'hffff);
      prog[1][1] = lit_form(AL, opc_ldh, 4'd1, 16'hffff);
      prog[1][2] = reg_form(AL, opc_mov, 4'd2, 4'd1, 4'd0, alu_add);
      prog[1][3] = lit_form(AL, opc_ldl0, 4'd2, 16'h0001);   // clears the ones above
      prog[1][4] = reg_form(AL, opc_op, 4'd3, 4'd1, 4'd2, alu_add);
      prog[1][5] = reg_form(AL, opc_op, 4'd4, 4'd2, 4'd2, alu_adc);
      chk_reg[1] = 4'd4;
      exp_tab[1] = 32'd3;
      // 5 - 7 borrows and 7 - 5 takes the borrow
      prog[2][0] = lit_form(AL, opc_ldl0, 4'd1, 16'd5);
      prog[2][1] = lit_form(AL, opc_ldl0, 4'd2, 16'd7);
      prog[2][2] = reg_form(AL, opc_op, 4'd3, 4'd1, 4'd2, alu_sub);
      prog[2][3] = reg_form(AL, opc_op, 4'd4, 4'd2, 4'd1, alu_sbc);
      chk_reg[2] = 4'd4;
      exp_tab[2] = 32'd1;
      // xor then shift left and back right
      prog[3][0] = lit_form(AL, opc_ldl, 4'd1, k[15:0]);
      prog[3][1] = lit_form(AL, opc_ldh, 4'd1, k[31:16]);
      prog[3][2] = lit_form(AL, opc_ldl, 4'd2, m[15:0]);
      prog[3][3] = lit_form(AL, opc_ldh, 4'd2, m[31:16]);
      prog[3][4] = reg_form(AL, opc_op, 4'd3, 4'd1, 4'd2, alu_xor);
      prog[3][5] = reg_form(AL, opc_op, 4'd4, 4'd3, 4'd0, alu_shl);
      prog[3][6] = reg_form(AL, opc_op, 4'd5, 4'd4, 4'd0, alu_shr);
      chk_reg[3] = 4'd5;
      exp_tab[3] = (k ^ m) & 32'h7fff_ffff;
      // 1 - 1 sets z before one failing and one passing test
      for (int t = 4; t < 6; t++) begin
         prog[t][0] = lit_form(AL, opc_ldl0, 4'd1, 16'd1);
         prog[t][1] = lit_form(AL, opc_ldl0, 4'd2, 16'd1);
         prog[t][2] = reg_form(AL, opc_op, 4'd3, 4'd1, 4'd2, alu_sub);
         prog[t][3] = lit_form(IF_NZ, opc_ldl0, 4'd4, 16'h0011);
         prog[t][4] = lit_form(IF_Z, opc_ldl0, 4'd5, 16'h0022);
      end
      chk_reg[4] = 4'd4;
      exp_tab[4] = 32'd0;
      chk_reg[5] = 4'd5;
      exp_tab[5] = 32'h22;
      // store m at 0x80 and load it back
      prog[6][0] = lit_form(AL, opc_ldl0, 4'd1, 16'h0080);
      prog[6][1] = lit_form(AL, opc_ldl, 4'd2, m[15:0]);
      prog[6][2] = lit_form(AL, opc_ldh, 4'd2, m[31:16]);
      prog[6][3] = reg_form(AL, opc_st, 4'd2, 4'd1, 4'd0, alu_add);
      prog[6][4] = reg_form(AL, opc_ld, 4'd3, 4'd1, 4'd0, alu_add);
      chk_reg[6] = 4'd3;
      exp_tab[6] = m;
      st_tab[6] = 1'b1;
      st_addr_tab[6] = 32'h80;
      st_data_tab[6] = m;
      // call to address 5 over words that would spoil the marker
      for (int t = 7; t < 9; t++) begin
         prog[t][0] = call_form(27'd5);
         for (int w = 1; w < 5; w++) prog[t][w] = lit_form(AL, opc_ldh, 4'd6, 16'h0033);
         prog[t][5] = lit_form(AL, opc_ldl, 4'd6, 16'h005a);   // marker
      end
      chk_reg[7] = 4'd14;   // return address
      exp_tab[7] = 32'd1;
      chk_reg[8] = 4'd6;
      exp_tab[8] = 32'h5a;
      // nops only
      chk_reg[9] = 4'd6;   // written by the entry before
      exp_tab[9] = 32'd0;

      for (int t = 0; t < NT; t++) begin
         @(posedge clk);
         cur <= t;
         exp_val <= exp_tab[t];
         exp_st <= st_tab[t];
         exp_addr <= st_addr_tab[t];
         exp_data <= st_data_tab[t];
         arst_n <= 1'b0;
         repeat (4) @(posedge clk);
         arst_n <= 1'b1;
         repeat (32) @(posedge clk);   // eight instructions
         test_sel <= chk_reg[t];
         @(posedge clk);
         check_en <= 1'b1;
         @(posedge clk);
         check_en <= 1'b0;
      end
      @(posedge clk);
      $display("checks done, %0d errors", errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/cpu_pkg.sv
verilog/schedm.sv
verilog/inst_decode.sv
verilog/alu.sv
verilog/rfm.sv
verilog/cpu.sv
tests/cpu_checker.sv
tests/cpu_props.sv
tests/tb_cpu.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --assert -j 0
TOP       = tb_cpu
FILELIST  = list.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

lint:
	$(VERILATOR) --lint-only --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
